// File: logic/rv_isa_pkg.sv
// ==============================
// RV64I subset ISA definitions: widths, opcodes
// and the instruction format union for decoding
// ==============================
`default_nettype none

package rv_isa_pkg;

  localparam int xlen     = 64;          // Data path width
  localparam int inst_w   = 32;          // Instruction word
  localparam int reg_id_w = 5;           // Register index

  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_op     = 7'b0110011;
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_system = 7'b1110011; // EBREAK lives here

  localparam logic [6:0] funct7_base = 7'b0000000;
  localparam logic [6:0] funct7_alt  = 7'b0100000; // SUB / SRA

  typedef struct packed {
    logic [6:0]          funct7;
    logic [reg_id_w-1:0] rs2;
    logic [reg_id_w-1:0] rs1;
    logic [2:0]          funct3;
    logic [reg_id_w-1:0] rd;
    logic [6:0]          opcode;
  } inst_r_t;

  typedef struct packed {
    logic [11:0]         imm_11_0;    // Also shamt plus shift type
    logic [reg_id_w-1:0] rs1;
    logic [2:0]          funct3;
    logic [reg_id_w-1:0] rd;
    logic [6:0]          opcode;
  } inst_i_t;

  typedef struct packed {
    logic [6:0]          imm_11_5;
    logic [reg_id_w-1:0] rs2;
    logic [reg_id_w-1:0] rs1;
    logic [2:0]          funct3;
    logic [4:0]          imm_4_0;
    logic [6:0]          opcode;
  } inst_s_t;

  typedef struct packed {
    logic [19:0]         imm_31_12;
    logic [reg_id_w-1:0] rd;
    logic [6:0]          opcode;
  } inst_u_t;

  typedef struct packed {
    logic                imm_20;      // Sign bit
    logic [9:0]          imm_10_1;
    logic                imm_11;
    logic [7:0]          imm_19_12;
    logic [reg_id_w-1:0] rd;
    logic [6:0]          opcode;
  } inst_j_t;

  // Same word viewed in every format at once
  typedef union packed {
    inst_r_t r;
    inst_i_t i;
    inst_s_t s;
    inst_u_t u;
    inst_j_t j;
  } inst_u;

endpackage

`default_nettype wire

// File: logic/core_ctrl_pkg.sv
// ==============================
// Core control encodings: one-hot ALU op
// bit positions and data RAM sizing
// ==============================
`default_nettype none

package core_ctrl_pkg;

  localparam int alu_op_w = 10;   // One bit per ALU function

  localparam int alu_add = 0;     // Also address and jump target adds
  localparam int alu_sub = 1;
  localparam int alu_lt  = 2;     // Signed compare
  localparam int alu_ltu = 3;     // Unsigned compare
  localparam int alu_and = 4;
  localparam int alu_or  = 5;
  localparam int alu_xor = 6;
  localparam int alu_sll = 7;
  localparam int alu_srl = 8;
  localparam int alu_sra = 9;

  // Data RAM, 64-bit words
  localparam int ram_words  = 32;
  localparam int ram_addr_w = 5;  // Byte address bits 7:3

endpackage

`default_nettype wire

// File: logic/inst_decoder.sv
// ==============================
// Decode stage: registers control, immediate and
// register indices for execute, and holds the halt level
// ==============================
`timescale 1ns/10ps
`default_nettype none

module inst_decoder import rv_isa_pkg::*, core_ctrl_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                inst_valid,
  input  inst_u               inst,
  input  logic [xlen-1:0]     pc,
  output logic                halted,
  output logic                dec_valid,
  output logic [xlen-1:0]     dec_pc,
  output logic [reg_id_w-1:0] dec_rd,
  output logic [reg_id_w-1:0] dec_rs1,
  output logic [reg_id_w-1:0] dec_rs2,
  output logic [xlen-1:0]     dec_imm,
  output logic                dec_use_imm,
  output logic [alu_op_w-1:0] dec_alu_op,
  output logic                dec_reg_wen,
  output logic                dec_mem_wen,
  output logic                dec_is_load,
  output logic                dec_is_auipc,
  output logic                dec_is_jal,
  output logic                dec_is_jalr,
  output logic                dec_is_ebreak,
  output logic                dec_illegal
);

  logic [7:0]          f3;                        // One-hot funct3
  logic                is_i, r_base, r_alt;       // OP-IMM, OP, OP with alt funct7
  logic                sh_base, sh_alt;           // Shift immediate top bits
  logic                lui, auipc, jal, jalr, ld, sd, ebreak;
  logic [alu_op_w-1:0] alu_op;
  logic [xlen-1:0]     imm;
  logic                take;                      // Accepted this cycle
  logic                legal;

  assign f3      = 8'b1 << inst.r.funct3;
  assign is_i    = inst.r.opcode == op_imm;
  assign r_base  = (inst.r.opcode == op_op) && (inst.r.funct7 == funct7_base);
  assign r_alt   = (inst.r.opcode == op_op) && (inst.r.funct7 == funct7_alt);
  assign sh_base = inst.i.imm_11_0[11:6] == 6'b000000;
  assign sh_alt  = inst.i.imm_11_0[11:6] == 6'b010000;
  assign lui     = inst.r.opcode == op_lui;
  assign auipc   = inst.r.opcode == op_auipc;
  assign jal     = inst.r.opcode == op_jal;
  assign jalr    = (inst.r.opcode == op_jalr) && f3[0];
  assign ld      = (inst.r.opcode == op_load) && f3[3];   // 64-bit only
  assign sd      = (inst.r.opcode == op_store) && f3[3];
  assign ebreak  = (inst.i.opcode == op_system) && f3[0] && (inst.i.rd == '0) &&
                   (inst.i.rs1 == '0) && (inst.i.imm_11_0 == 12'h001);

  // One-hot op; every address or link add goes through alu_add
  always_comb begin
    alu_op          = '0;
    alu_op[alu_add] = ((is_i | r_base) & f3[0]) | lui | auipc | jal | jalr | ld | sd;
    alu_op[alu_sub] = r_alt & f3[0];
    alu_op[alu_lt]  = (is_i | r_base) & f3[2];
    alu_op[alu_ltu] = (is_i | r_base) & f3[3];
    alu_op[alu_xor] = (is_i | r_base) & f3[4];
    alu_op[alu_or]  = (is_i | r_base) & f3[6];
    alu_op[alu_and] = (is_i | r_base) & f3[7];
    alu_op[alu_sll] = ((is_i & sh_base) | r_base) & f3[1];
    alu_op[alu_srl] = ((is_i & sh_base) | r_base) & f3[5];
    alu_op[alu_sra] = ((is_i & sh_alt) | r_alt) & f3[5];
  end

  assign legal = (|alu_op) | ebreak;             // Unmatched encodings fall out here
  assign take  = inst_valid & ~halted;

  always_comb begin
    if (sd) begin
      imm = {{(xlen-12){inst.s.imm_11_5[6]}}, inst.s.imm_11_5, inst.s.imm_4_0};
    end else if (lui | auipc) begin
      imm = {{(xlen-32){inst.u.imm_31_12[19]}}, inst.u.imm_31_12, 12'h000};
    end else if (jal) begin
      imm = {{(xlen-21){inst.j.imm_20}}, inst.j.imm_20, inst.j.imm_19_12,
             inst.j.imm_11, inst.j.imm_10_1, 1'b0};
    end else begin
      imm = {{(xlen-12){inst.i.imm_11_0[11]}}, inst.i.imm_11_0}; // I format
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      halted        <= 1'b0;
      dec_valid     <= 1'b0;
      dec_reg_wen   <= 1'b0;
      dec_mem_wen   <= 1'b0;
      dec_is_load   <= 1'b0;
      dec_is_auipc  <= 1'b0;
      dec_is_jal    <= 1'b0;
      dec_is_jalr   <= 1'b0;
      dec_is_ebreak <= 1'b0;
      dec_illegal   <= 1'b0;
    end else begin
      dec_valid     <= take;
      dec_reg_wen   <= take & (|alu_op) & ~sd & (inst.r.rd != '0); // x0 never written
      dec_mem_wen   <= take & sd;
      dec_is_load   <= take & ld;
      dec_is_auipc  <= take & auipc;
      dec_is_jal    <= take & jal;
      dec_is_jalr   <= take & jalr;
      dec_is_ebreak <= take & ebreak;
      dec_illegal   <= take & ~legal;
      if (take & ebreak) halted <= 1'b1;         // Sticky until reset
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      dec_pc      <= pc;
      dec_rd      <= inst.r.rd;
      dec_rs1     <= (lui | jal) ? '0 : inst.r.rs1; // Zero operand A for LUI
      dec_rs2     <= inst.r.rs2;
      dec_imm     <= imm;
      dec_use_imm <= ~(r_base | r_alt);
      dec_alu_op  <= alu_op;
    end
  end

endmodule

`default_nettype wire

// File: logic/exec_stage.sv
// ==============================
// Execute stage: forwarding, ALU, RAM access
// and the retire register that feeds writeback
// ==============================
`timescale 1ns/10ps
`default_nettype none

module exec_stage import rv_isa_pkg::*, core_ctrl_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  dec_valid,
  input  logic [xlen-1:0]       dec_pc,
  input  logic [reg_id_w-1:0]   dec_rd,
  input  logic [reg_id_w-1:0]   dec_rs1,
  input  logic [reg_id_w-1:0]   dec_rs2,
  input  logic [xlen-1:0]       dec_imm,
  input  logic                  dec_use_imm,
  input  logic [alu_op_w-1:0]   dec_alu_op,
  input  logic                  dec_reg_wen,
  input  logic                  dec_mem_wen,
  input  logic                  dec_is_load,
  input  logic                  dec_is_auipc,
  input  logic                  dec_is_jal,
  input  logic                  dec_is_jalr,
  input  logic                  dec_is_ebreak,
  input  logic                  dec_illegal,
  input  logic [xlen-1:0]       rs1_data,
  input  logic [xlen-1:0]       rs2_data,
  input  logic [xlen-1:0]       ram_rdata,
  output logic [ram_addr_w-1:0] ram_addr,
  output logic [xlen-1:0]       ram_wdata,
  output logic                  ram_wen,
  output logic                  retire_valid,
  output logic [xlen-1:0]       retire_pc,
  output logic                  retire_wen,
  output logic [reg_id_w-1:0]   retire_rd,
  output logic [xlen-1:0]       retire_data,
  output logic                  redirect_valid,
  output logic [xlen-1:0]       redirect_target,
  output logic                  illegal
);

  logic [xlen-1:0] src1, src2;           // Forwarded register values
  logic [xlen-1:0] op_a, op_b, sum, alu_res, result;
  logic [5:0]      shamt;                // RV64 shift amount

  // Previous instruction's result is not in the register file yet
  assign src1  = (retire_wen && retire_rd == dec_rs1) ? retire_data : rs1_data;
  assign src2  = (retire_wen && retire_rd == dec_rs2) ? retire_data : rs2_data;
  assign op_a  = (dec_is_auipc | dec_is_jal) ? dec_pc : src1;
  assign op_b  = dec_use_imm ? dec_imm : src2;
  assign sum   = op_a + op_b;
  assign shamt = op_b[5:0];

  assign alu_res = ({xlen{dec_alu_op[alu_add]}} & sum) |
                   ({xlen{dec_alu_op[alu_sub]}} & (op_a - op_b)) |
                   ({xlen{dec_alu_op[alu_lt]}}  & xlen'($signed(op_a) < $signed(op_b))) |
                   ({xlen{dec_alu_op[alu_ltu]}} & xlen'(op_a < op_b)) |
                   ({xlen{dec_alu_op[alu_and]}} & (op_a & op_b)) |
                   ({xlen{dec_alu_op[alu_or]}}  & (op_a | op_b)) |
                   ({xlen{dec_alu_op[alu_xor]}} & (op_a ^ op_b)) |
                   ({xlen{dec_alu_op[alu_sll]}} & (op_a << shamt)) |
                   ({xlen{dec_alu_op[alu_srl]}} & (op_a >> shamt)) |
                   ({xlen{dec_alu_op[alu_sra]}} & xlen'($signed(op_a) >>> shamt));

  always_comb begin
    if (dec_is_load) result = ram_rdata;
    else if (dec_is_jal | dec_is_jalr) result = dec_pc + xlen'(4); // Link address
    else if (dec_is_ebreak | dec_illegal) result = '0;
    else result = alu_res;
  end

  assign ram_addr  = sum[ram_addr_w+2:3];  // Word index of the byte address
  assign ram_wdata = src2;
  assign ram_wen   = dec_mem_wen;          // Already qualified by valid

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      retire_valid   <= 1'b0;
      retire_wen     <= 1'b0;
      redirect_valid <= 1'b0;
      illegal        <= 1'b0;
    end else begin
      retire_valid   <= dec_valid;
      retire_wen     <= dec_reg_wen;
      redirect_valid <= dec_is_jal | dec_is_jalr;
      illegal        <= dec_illegal;
    end
  end

  always_ff @(posedge clk) begin
    if (dec_valid) begin
      retire_pc       <= dec_pc;
      retire_rd       <= dec_rd;
      retire_data     <= result;
      redirect_target <= {sum[xlen-1:1], sum[0] & ~dec_is_jalr}; // JALR clears bit 0
    end
  end

endmodule

`default_nettype wire

// File: logic/reg_file.sv
// ==============================
// Integer registers x1..x31, x0 reads as zero
// ==============================
`timescale 1ns/10ps
`default_nettype none

module reg_file import rv_isa_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  input  logic [reg_id_w-1:0] rs1,
  input  logic [reg_id_w-1:0] rs2,
  output logic [xlen-1:0]     rs1_data,
  output logic [xlen-1:0]     rs2_data,
  input  logic                wen,
  input  logic [reg_id_w-1:0] wr_id,
  input  logic [xlen-1:0]     wr_data
);

  logic [xlen-1:0] regs [1:31];          // No storage for x0

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int k = 1; k < 32; k++) regs[k] <= '0;
    end else if (wen) begin
      regs[wr_id] <= wr_data;            // wr_id is never 0 here
    end
  end

  // Combinational reads, same-cycle writes not bypassed
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// File: logic/data_ram.sv
// ==============================
// Data memory, full 64-bit words only
// ==============================
`timescale 1ns/10ps
`default_nettype none

module data_ram import rv_isa_pkg::*, core_ctrl_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [ram_addr_w-1:0] addr,
  input  logic [xlen-1:0]       wdata,
  input  logic                  wen,
  output logic [xlen-1:0]       rdata
);

  logic [xlen-1:0] mem [ram_words];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int k = 0; k < ram_words; k++) mem[k] <= '0; // Reads zero until written
    end else if (wen) begin
      mem[addr] <= wdata;
    end
  end

  assign rdata = mem[addr];              // Async read for LD in execute

endmodule

`default_nettype wire

// File: logic/core_top.sv
// ==============================
// Core top: decode, execute, register file and RAM
// ==============================
`timescale 1ns/10ps
`default_nettype none

module core_top import rv_isa_pkg::*, core_ctrl_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                inst_valid,
  input  logic [inst_w-1:0]   inst,
  input  logic [xlen-1:0]     pc,
  output logic                retire_valid,
  output logic [xlen-1:0]     retire_pc,
  output logic                retire_wen,
  output logic [reg_id_w-1:0] retire_rd,
  output logic [xlen-1:0]     retire_data,
  output logic                redirect_valid,
  output logic [xlen-1:0]     redirect_target,
  output logic                illegal,
  output logic                halted
);

  logic                  dec_valid, dec_use_imm, dec_reg_wen, dec_mem_wen;
  logic                  dec_is_load, dec_is_auipc, dec_is_jal, dec_is_jalr;
  logic                  dec_is_ebreak, dec_illegal;
  logic [xlen-1:0]       dec_pc, dec_imm;
  logic [reg_id_w-1:0]   dec_rd, dec_rs1, dec_rs2;
  logic [alu_op_w-1:0]   dec_alu_op;
  logic [xlen-1:0]       rs1_data, rs2_data;        // Register file reads
  logic [ram_addr_w-1:0] ram_addr;
  logic [xlen-1:0]       ram_wdata, ram_rdata;
  logic                  ram_wen;

  inst_decoder u_dec (
    .clk, .rst_n, .inst_valid, .inst, .pc, .halted,
    .dec_valid, .dec_pc, .dec_rd, .dec_rs1, .dec_rs2, .dec_imm, .dec_use_imm,
    .dec_alu_op, .dec_reg_wen, .dec_mem_wen, .dec_is_load, .dec_is_auipc,
    .dec_is_jal, .dec_is_jalr, .dec_is_ebreak, .dec_illegal
  );

  exec_stage u_exec (
    .clk, .rst_n,
    .dec_valid, .dec_pc, .dec_rd, .dec_rs1, .dec_rs2, .dec_imm, .dec_use_imm,
    .dec_alu_op, .dec_reg_wen, .dec_mem_wen, .dec_is_load, .dec_is_auipc,
    .dec_is_jal, .dec_is_jalr, .dec_is_ebreak, .dec_illegal,
    .rs1_data, .rs2_data, .ram_rdata, .ram_addr, .ram_wdata, .ram_wen,
    .retire_valid, .retire_pc, .retire_wen, .retire_rd, .retire_data,
    .redirect_valid, .redirect_target, .illegal
  );

  // Retire port doubles as the writeback port
  reg_file u_rf (
    .clk, .rst_n, .rs1(dec_rs1), .rs2(dec_rs2), .rs1_data, .rs2_data,
    .wen(retire_wen), .wr_id(retire_rd), .wr_data(retire_data)
  );

  data_ram u_ram (
    .clk, .rst_n, .addr(ram_addr), .wdata(ram_wdata), .wen(ram_wen), .rdata(ram_rdata)
  );

endmodule

`default_nettype wire

// File: dv/tb_clk_gen.sv
// ==============================
// Free-running testbench clock
// ==============================
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen #(
  parameter int period = 40              // ns
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

endmodule

`default_nettype wire

// File: dv/core_assert.sv
// ==============================
// Retire and halt properties bound into core_top
// ==============================
`timescale 1ns/10ps
`default_nettype none

module core_assert (
  input logic clk,
  input logic rst_n,
  input logic retire_valid,
  input logic retire_wen,
  input logic illegal,
  input logic halted
);

  // Pipeline is empty while reset is held
  a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !retire_valid)
    else $error("retire_valid high while in reset");

  // EBREAK itself retires but nothing after it
  a_halt_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    halted && $past(halted) |=> !retire_valid)
    else $error("instruction retired after the core halted");

  a_illegal_nowrite: assert property (@(posedge clk) disable iff (!rst_n)
    illegal |-> !retire_wen)
    else $error("register write on an illegal instruction");

endmodule

`default_nettype wire

// File: dv/tb_core.sv
// ==============================
// Core testbench: random RV64I subset stimulus
// compared per retire against an ISA model
// ==============================
`timescale 1ns/10ps
`default_nettype none

module tb_core import rv_isa_pkg::*; ();

  localparam int n_fill  = 62;           // LUI plus XORI per register
  localparam int n_imm   = 60;
  localparam int n_reg   = 90;           // Last 30 back to back
  localparam int n_uj    = 30;
  localparam int n_mem   = 64;
  localparam int n_bad   = 20;
  localparam int n_read  = 31;
  localparam int n_tail  = 6;            // EBREAK plus ignored ones
  localparam int n_total = n_fill + n_imm + n_reg + n_uj + n_mem + n_bad + n_read + n_tail;
  localparam logic [31:0] ebreak_word = 32'h00100073;

  typedef struct packed {
    logic [xlen-1:0]     pc, data, target;
    logic [reg_id_w-1:0] rd;
    logic                wen, jump, bad, halt, st;
    logic [4:0]          st_idx;         // RAM word hit by SD
    logic [xlen-1:0]     st_data;
  } exp_t;

  logic                clk, rst_n, inst_valid;
  logic [inst_w-1:0]   inst;
  logic [xlen-1:0]     pc, pc_next;
  logic                retire_valid, retire_wen, redirect_valid, illegal, halted;
  logic [xlen-1:0]     retire_pc, retire_data, redirect_target;
  logic [reg_id_w-1:0] retire_rd;
  logic [xlen-1:0]     regs [32];        // Architectural model state
  logic [xlen-1:0]     ram [32];
  exp_t                exp_q [$];        // Issued, not yet retired
  logic                model_halted;
  int                  errors = 0;
  int                  retired = 0;
  int                  sent = 0;

  tb_clk_gen #(.period(40)) u_clk (.clk);

  core_top DUT (
    .clk, .rst_n, .inst_valid, .inst, .pc, .retire_valid, .retire_pc, .retire_wen,
    .retire_rd, .retire_data, .redirect_valid, .redirect_target, .illegal, .halted
  );

  bind core_top core_assert u_assert (.*);

  function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, rs1,
                                        logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, op_op};
  endfunction

  function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1,
                                        logic [2:0] f3, logic [4:0] rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, rs1);
    return {imm[11:5], rs2, rs1, 3'd3, imm[4:0], op_store};  // SD only
  endfunction

  function automatic logic [31:0] enc_u(logic [19:0] imm, logic [4:0] rd, logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
  endfunction

  function automatic logic [4:0] pick_reg();
    return 5'($urandom_range(31, 0));
  endfunction

  function automatic int pick_gap();
    return int'($urandom_range(2, 0));
  endfunction

  // RV64I integer ops, shifts use 6 bits
  function automatic logic [xlen-1:0] alu_ref(logic [2:0] f3, logic alt,
                                              logic [xlen-1:0] a, b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[5:0];
      3'd2:    return 64'($signed(a) < $signed(b));
      3'd3:    return 64'(a < b);
      3'd4:    return a ^ b;
      3'd5:    return alt ? 64'($signed(a) >>> b[5:0]) : a >> b[5:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  // Expected retire for one word against current model state
  function automatic exp_t model_exec(logic [31:0] word, logic [xlen-1:0] at);
    exp_t            e;
    inst_u           d;
    logic [xlen-1:0] a, b, ea, imm_i, imm_s, imm_u, imm_j;
    logic [2:0]      f3;
    logic [5:0]      top;
    logic            wr;
    d     = word;
    e     = '0;
    e.pc  = at;
    e.rd  = d.r.rd;
    a     = regs[d.r.rs1];
    b     = regs[d.r.rs2];
    f3    = d.r.funct3;
    top   = d.i.imm_11_0[11:6];
    imm_i = {{52{d.i.imm_11_0[11]}}, d.i.imm_11_0};
    imm_s = {{52{d.s.imm_11_5[6]}}, d.s.imm_11_5, d.s.imm_4_0};
    imm_u = {{32{d.u.imm_31_12[19]}}, d.u.imm_31_12, 12'h000};
    imm_j = {{43{d.j.imm_20}}, d.j.imm_20, d.j.imm_19_12, d.j.imm_11, d.j.imm_10_1, 1'b0};
    wr    = 1'b1;
    case (d.r.opcode)
      op_imm: begin
        e.bad  = (f3 == 3'd1 && top != 6'h00) ||
                 (f3 == 3'd5 && top != 6'h00 && top != 6'h10);
        e.data = alu_ref(f3, f3 == 3'd5 && top == 6'h10, a, imm_i);
      end
      op_op: begin
        e.bad  = !(d.r.funct7 == funct7_base ||
                   (d.r.funct7 == funct7_alt && (f3 == 3'd0 || f3 == 3'd5)));
        e.data = alu_ref(f3, d.r.funct7 == funct7_alt, a, b);
      end
      op_lui:   e.data = imm_u;
      op_auipc: e.data = at + imm_u;
      op_jal: begin
        e.data   = at + 64'd4;
        e.jump   = 1'b1;
        e.target = at + imm_j;
      end
      op_jalr: begin
        e.bad    = f3 != 3'd0;
        e.data   = at + 64'd4;
        e.jump   = !e.bad;
        e.target = (a + imm_i) & ~64'h1;  // Low bit dropped
      end
      op_load: begin
        ea     = a + imm_i;
        e.bad  = f3 != 3'd3;
        e.data = ram[ea[7:3]];
      end
      op_store: begin
        ea        = a + imm_s;
        e.bad     = f3 != 3'd3;
        wr        = 1'b0;
        e.st      = !e.bad;
        e.st_idx  = ea[7:3];
        e.st_data = b;
      end
      op_system: begin
        e.bad  = word != ebreak_word;
        wr     = 1'b0;
        e.halt = !e.bad;
      end
      default: e.bad = 1'b1;
    endcase
    e.wen = wr && !e.bad && d.r.rd != 5'd0;
    return e;
  endfunction

  task automatic report(input string name, input logic [xlen-1:0] got,
                        input logic [xlen-1:0] want);
    errors++;
    $display("** Error: %s = %h, expected %h (pc %h)", name, got, want, retire_pc);
  endtask

  // Issue one word after gap idle cycles, model it unless halted
  task automatic send(input logic [31:0] word, input int gap);
    exp_t e;
    repeat (gap) begin
      @(posedge clk);
      #2 inst_valid = 1'b0;
    end
    @(posedge clk);
    #2;
    e          = model_exec(word, pc_next);
    inst_valid = 1'b1;
    inst       = word;
    pc         = pc_next;
    if (!model_halted) begin
      exp_q.push_back(e);
      if (e.wen) regs[e.rd] = e.data;
      if (e.st) ram[e.st_idx] = e.st_data;
      if (e.halt) model_halted = 1'b1;
    end
    pc_next = pc_next + 64'd4;
    sent++;
  endtask

  always @(negedge clk) begin : monitor
    exp_t e;
    if (rst_n && retire_valid) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("Retire at pc %h with no instruction outstanding", retire_pc);
      end else begin
        e = exp_q.pop_front();
        retired++;
        if (retire_pc !== e.pc) report("retire_pc", retire_pc, e.pc);
        if (retire_wen !== e.wen) report("retire_wen", 64'(retire_wen), 64'(e.wen));
        if (illegal !== e.bad) report("illegal", 64'(illegal), 64'(e.bad));
        if (redirect_valid !== e.jump)
          report("redirect_valid", 64'(redirect_valid), 64'(e.jump));
        if (e.wen && retire_rd !== e.rd) report("retire_rd", 64'(retire_rd), 64'(e.rd));
        if (e.wen && retire_data !== e.data) report("retire_data", retire_data, e.data);
        if (e.jump && redirect_target !== e.target)
          report("redirect_target", redirect_target, e.target);
        if (e.halt && halted !== 1'b1) begin
          errors++;
          $display("halted did not rise by the time EBREAK retired");
        end
      end
    end
  end

  initial begin : watchdog
    #((n_total * 3 + 20) * 40);
    $display("Watchdog expired with %0d retires still pending", exp_q.size());
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin : stimulus
    logic [2:0]  f3;
    logic [11:0] imm;
    logic [4:0]  rd, rs1, last_rd;
    logic [6:0]  f7;
    logic [31:0] word;
    exp_t        probe;
    void'($urandom(2));
    rst_n        = 1'b0;
    inst_valid   = 1'b0;
    inst         = '0;
    pc           = '0;
    pc_next      = '0;
    model_halted = 1'b0;
    for (int k = 0; k < 32; k++) begin
      regs[k] = '0;
      ram[k]  = '0;
    end
    repeat (4) @(posedge clk);
    #2 rst_n = 1'b1;
    for (int k = 1; k < 32; k++) begin                     // Wide values in every register
      send(enc_u(20'($urandom), 5'(k), op_lui), pick_gap());
      send(enc_i(12'($urandom), 5'(k), 3'd4, 5'(k), op_imm), pick_gap());
    end
    for (int k = 0; k < n_imm; k++) begin
      f3  = 3'($urandom);
      imm = 12'($urandom);
      if (f3 == 3'd1) imm[11:6] = 6'h00;
      if (f3 == 3'd5) imm[11:6] = $urandom_range(1, 0) ? 6'h10 : 6'h00;  // SRAI or SRLI
      send(enc_i(imm, pick_reg(), f3, pick_reg(), op_imm), pick_gap());
    end
    last_rd = 5'd1;
    for (int k = 0; k < n_reg; k++) begin
      f3  = 3'($urandom);
      f7  = ((f3 == 3'd0 || f3 == 3'd5) && $urandom_range(1, 0)) ? funct7_alt : funct7_base;
      rs1 = (k >= 60) ? last_rd : pick_reg();              // Dependent chain at the end
      rd  = (k % 8 == 0) ? 5'd0 : pick_reg();
      send(enc_r(f7, pick_reg(), rs1, f3, rd), (k >= 60) ? 0 : pick_gap());
      if (rd != 5'd0) last_rd = rd;
    end
    for (int k = 0; k < n_uj; k++) begin
      rd = pick_reg();
      case ($urandom_range(3, 0))
        0:       word = enc_u(20'($urandom), rd, op_lui);
        1:       word = enc_u(20'($urandom), rd, op_auipc);
        2:       word = enc_j({20'($urandom), 1'b0}, rd);
        default: word = enc_i(12'($urandom), pick_reg(), 3'd0, rd, op_jalr);
      endcase
      send(word, pick_gap());
    end
    for (int k = 0; k < 24; k++) begin
      imm = {4'h0, 5'($urandom), 3'b000};                  // Aligned, first 256 bytes
      send(enc_s(imm, pick_reg(), 5'd0), pick_gap());
      send(enc_i(imm, 5'd0, 3'd3, pick_reg(), op_load), pick_gap());
    end
    for (int k = 0; k < 16; k++) begin                     // Some words never stored
      send(enc_i({4'h0, 5'($urandom), 3'b000}, 5'd0, 3'd3, pick_reg(), op_load), pick_gap());
    end
    for (int k = 0; k < n_bad; k++) begin
      do begin
        word = $urandom;
        case ($urandom_range(4, 0))                        // Bias toward near misses
          0:       word[6:0] = op_op;
          1:       word[6:0] = op_load;
          2:       word[6:0] = op_jalr;
          3:       word[6:0] = op_system;
          default: ;
        endcase
        probe = model_exec(word, pc_next);
      end while (!probe.bad);
      send(word, pick_gap());
    end
    for (int k = 1; k < 32; k++) begin                     // Read back every register
      send(enc_i(12'h000, 5'(k), 3'd0, 5'(k), op_imm), pick_gap());
    end
    send(ebreak_word, 0);
    for (int k = 0; k < n_tail - 1; k++) begin
      send(enc_i(12'($urandom), pick_reg(), 3'd0, pick_reg(), op_imm), 0);
    end
    @(posedge clk);
    #2 inst_valid = 1'b0;
    while (exp_q.size() != 0) @(posedge clk);
    repeat (8) @(negedge clk);                             // Nothing more may retire
    if (!halted) begin
      errors++;
      $display("Core is not halted after EBREAK");
    end
    $display("Retired %0d of %0d issued, %0d errors", retired, sent, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
logic/rv_isa_pkg.sv
logic/core_ctrl_pkg.sv
logic/inst_decoder.sv
logic/exec_stage.sv
logic/reg_file.sv
logic/data_ram.sv
logic/core_top.sv
dv/tb_clk_gen.sv
dv/core_assert.sv
dv/tb_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_core
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= ALL TESTS PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
